// ==== filelist.f ====
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_mult.sv
logic/ex_writeback.sv
logic/ex_stage.sv
tb/tb_ex_stage.sv

// ==== logic/ex_alu.sv ====
// Purely combinational integer ALU. No enable and no ready, the result is valid in the
// request cycle. Shift amounts use only the low five bits of operand_b.

`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
  // Operator and operands from decode
  input  alu_req_t        alu_req_i,

  // Result towards the forwarding mux
  output logic [XLEN-1:0] result_o,
  // Branch comparison outcome
  output logic            cmp_result_o
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;

  // Shared adder
  logic            adder_sub;
  logic [XLEN-1:0] adder_b;
  logic [XLEN:0]   adder_full;
  logic [XLEN-1:0] adder_result;

  // Comparison flags
  logic            is_equal;
  logic            lt_unsigned;
  logic            lt_signed;

  // Shifter
  logic [4:0]      shamt;
  logic            shift_arith;
  logic [XLEN:0]   shift_right;
  logic [XLEN-1:0] shift_left;

  assign op_a = alu_req_i.operand_a;
  assign op_b = alu_req_i.operand_b;

  ////////////////////////////////////////////////////////////
  // Adder and comparison
  ////////////////////////////////////////////////////////////

  // Everything except ADD subtracts, so comparisons reuse the adder
  assign adder_sub    = (alu_req_i.op != ADD);
  assign adder_b      = adder_sub ? ~op_b : op_b;
  // Carry in of one completes the two's complement of operand_b
  assign adder_full   = {1'b0, op_a} + {1'b0, adder_b} + {{XLEN{1'b0}}, adder_sub};
  assign adder_result = adder_full[XLEN-1:0];

  assign is_equal    = ~|(op_a ^ op_b);
  // No carry out of a - b means a borrow, so a < b unsigned
  assign lt_unsigned = ~adder_full[XLEN];
  // Differing signs decide directly
  // Equal signs fall back to the unsigned result
  assign lt_signed   = (op_a[XLEN-1] != op_b[XLEN-1]) ? op_a[XLEN-1] : lt_unsigned;

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  assign shamt       = op_b[4:0];
  assign shift_arith = (alu_req_i.op == SRA);

  // One extra top bit carries the fill value for SRL and SRA alike
  assign shift_right = $signed({shift_arith & op_a[XLEN-1], op_a}) >>> shamt;
  assign shift_left  = op_a << shamt;

  ////////////////////////////////////////////////////////////
  // Branch comparison
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (alu_req_i.op)
      EQ:      cmp_result_o = is_equal;
      NE:      cmp_result_o = ~is_equal;
      LT:      cmp_result_o = lt_signed;
      GE:      cmp_result_o = ~lt_signed;
      LTU:     cmp_result_o = lt_unsigned;
      GEU:     cmp_result_o = ~lt_unsigned;
      // Non-compare operators never take a branch
      default: cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (alu_req_i.op)
      ADD, SUB: result_o = adder_result;
      AND:      result_o = op_a & op_b;
      OR:       result_o = op_a | op_b;
      XOR:      result_o = op_a ^ op_b;
      SLL:      result_o = shift_left;
      SRL, SRA: result_o = shift_right[XLEN-1:0];
      SLT:      result_o = {{(XLEN-1){1'b0}}, lt_signed};
      SLTU:     result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      // Comparisons also write their bit to the register file
      EQ, NE, LT, GE, LTU, GEU: begin
        result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
      end
      default:  result_o = '0;
    endcase
  end

endmodule

// ==== logic/ex_mult.sv ====
// Integer multiplier. MUL is single cycle, high-word products add exactly one cycle.
// The high word is held until ex_ready_i, so back-pressure never loses a result.

`timescale 1ns/1ps

module ex_mult import ex_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,

  // Request from decode
  input  logic            enable_i,
  input  mult_req_t       mult_req_i,

  // Stage handshake
  input  logic            ex_ready_i,

  output logic [XLEN-1:0] result_o,
  output logic            multicycle_o,
  output logic            ready_o
);

  typedef enum logic {
    IDLE,
    FINISH
  } mult_state_e;

  mult_state_e state_q;
  mult_state_e state_d;

  // Operand sign control
  logic sign_a;
  logic sign_b;

  logic signed [XLEN:0]     op_a_ext;
  logic signed [XLEN:0]     op_b_ext;
  logic signed [2*XLEN-1:0] product;

  // High word captured for the second cycle
  logic [XLEN-1:0] high_q;

  // A high-word product enters the FSM this cycle
  logic start_high;

  ////////////////////////////////////////////////////////////
  // Product
  ////////////////////////////////////////////////////////////

  // MULH treats both operands as signed, MULHSU only operand a
  assign sign_a = (mult_req_i.op == MULH) || (mult_req_i.op == MULHSU);
  assign sign_b = (mult_req_i.op == MULH);

  assign op_a_ext = $signed({sign_a & mult_req_i.op_a[XLEN-1], mult_req_i.op_a});
  assign op_b_ext = $signed({sign_b & mult_req_i.op_b[XLEN-1], mult_req_i.op_b});

  // 33x33 signed product from operands sign extended to the full width
  // Every legal result fits the low 64 bits
  assign product = (2*XLEN)'(op_a_ext) * (2*XLEN)'(op_b_ext);

  ////////////////////////////////////////////////////////////
  // High-word FSM
  ////////////////////////////////////////////////////////////

  assign start_high = enable_i && (state_q == IDLE) && (mult_req_i.op != MUL);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start_high) begin
          state_d = FINISH;
        end
      end
      FINISH: begin
        // Hold the word until the stage moves on
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Upper half of the product
  always_ff @(posedge clk) begin
    if (start_high) begin
      high_q <= product[2*XLEN-1:XLEN];
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Stall only in the capture cycle
  assign ready_o      = ~start_high;
  assign multicycle_o = start_high;

  // Low word for MUL, registered high word once the FSM finishes
  assign result_o = (state_q == FINISH) ? high_q : product[XLEN-1:0];

endmodule

// ==== logic/ex_pkg.sv ====
// Shared types for the execute stage. Data width is fixed at 32 bits by the structs below.
// Register addresses are 6 bits wide to match the decode stage.

package ex_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Integer data path width
  localparam int unsigned XLEN = 32;

  // Register file address width
  localparam int unsigned REG_ADDR_W = 6;

  ////////////////////////////////////////////////////////////
  // Operator encodings
  ////////////////////////////////////////////////////////////

  // ALU operators
  // The last six are branch comparisons
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9,
    EQ   = 4'd10,
    NE   = 4'd11,
    LT   = 4'd12,
    GE   = 4'd13,
    LTU  = 4'd14,
    GEU  = 4'd15
  } alu_op_e;

  // Multiplier operators
  // Only MUL finishes in one cycle
  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mult_op_e;

  ////////////////////////////////////////////////////////////
  // Request and write port bundles
  ////////////////////////////////////////////////////////////

  // ALU request from decode (68 bits)
  typedef struct packed {
    alu_op_e         op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } alu_req_t;

  // Multiplier request from decode (66 bits)
  typedef struct packed {
    mult_op_e        op;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
  } mult_req_t;

  // Register file write port (39 bits)
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } rf_wr_t;

endpackage

// ==== logic/ex_stage.sv ====
// Execute stage top with ALU, multiplier and write-back ports. No FPU and no division.
// Branches retire here, so ex_ready_o stays high for a branch even under WB back-pressure.

`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,

  // From decode
  input  alu_req_t              alu_req_i,
  input  logic                  alu_en_i,
  input  mult_req_t             mult_req_i,
  input  logic                  mult_en_i,
  input  logic                  csr_access_i,
  input  logic [XLEN-1:0]       csr_rdata_i,
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic                  branch_in_ex_i,

  // From the LSU
  input  logic                  lsu_en_i,
  input  logic [XLEN-1:0]       lsu_rdata_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  lsu_err_i,

  // From write-back
  input  logic                  wb_ready_i,

  // Write ports
  output rf_wr_t                alu_fw_o,
  output rf_wr_t                wb_o,

  output logic                  branch_decision_o,
  output logic                  mult_multicycle_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o
);

  logic [XLEN-1:0] alu_result;
  logic            alu_cmp_result;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;

  logic            units_ready;
  logic            ex_ready;
  logic            ex_valid;

  ////////////////////////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////////////////////////

  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;

  // Valid does not depend on ready, a branch finishes without WB
  assign ex_ready = units_ready | branch_in_ex_i;
  assign ex_valid = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  assign ex_ready_o        = ex_ready;
  assign ex_valid_o        = ex_valid;
  assign branch_decision_o = alu_cmp_result;

  ////////////////////////////////////////////////////////////
  // Units
  ////////////////////////////////////////////////////////////

  ex_alu i_alu (
    .alu_req_i   (alu_req_i),
    .result_o    (alu_result),
    .cmp_result_o(alu_cmp_result)
  );

  ex_mult i_mult (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable_i    (mult_en_i),
    .mult_req_i  (mult_req_i),
    .ex_ready_i  (ex_ready),
    .result_o    (mult_result),
    .multicycle_o(mult_multicycle_o),
    .ready_o     (mult_ready)
  );

  ex_writeback i_writeback (
    .clk                (clk),
    .rst_n              (rst_n),
    .alu_result_i       (alu_result),
    .mult_result_i      (mult_result),
    .csr_rdata_i        (csr_rdata_i),
    .lsu_rdata_i        (lsu_rdata_i),
    .alu_en_i           (alu_en_i),
    .mult_en_i          (mult_en_i),
    .csr_access_i       (csr_access_i),
    .regfile_alu_we_i   (regfile_alu_we_i),
    .regfile_alu_waddr_i(regfile_alu_waddr_i),
    .regfile_we_i       (regfile_we_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .lsu_err_i          (lsu_err_i),
    .ex_valid_i         (ex_valid),
    .wb_ready_i         (wb_ready_i),
    .alu_fw_o           (alu_fw_o),
    .wb_o               (wb_o)
  );

endmodule

// ==== logic/ex_writeback.sv ====
// Forwarding write port and EX/WB register for the load port.
// Load data is not registered here, it comes straight from the LSU.

`timescale 1ns/1ps

module ex_writeback import ex_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,

  // Result sources
  input  logic [XLEN-1:0]       alu_result_i,
  input  logic [XLEN-1:0]       mult_result_i,
  input  logic [XLEN-1:0]       csr_rdata_i,
  input  logic [XLEN-1:0]       lsu_rdata_i,

  // Source selects from decode
  input  logic                  alu_en_i,
  input  logic                  mult_en_i,
  input  logic                  csr_access_i,

  // Destination control
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,

  // LSU status and stage handshake
  input  logic                  lsu_err_i,
  input  logic                  ex_valid_i,
  input  logic                  wb_ready_i,

  output rf_wr_t                alu_fw_o,
  output rf_wr_t                wb_o
);

  // Load port pipeline state
  logic                  we_q;
  logic [REG_ADDR_W-1:0] waddr_q;

  // Faulted loads never write
  logic                  lsu_we;

  ////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_fw_o.we    = regfile_alu_we_i;
    alu_fw_o.waddr = regfile_alu_waddr_i;
    // CSR beats multiplier, multiplier beats ALU
    if (csr_access_i) begin
      alu_fw_o.wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      alu_fw_o.wdata = mult_result_i;
    end else if (alu_en_i) begin
      alu_fw_o.wdata = alu_result_i;
    end else begin
      alu_fw_o.wdata = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////

  assign lsu_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q    <= 1'b0;
      waddr_q <= '0;
    end else if (ex_valid_i) begin
      // Valid already implies WB ready
      we_q <= lsu_we;
      if (lsu_we) begin
        waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Nothing new, flush the old write
      we_q <= 1'b0;
    end
  end

  // Load write port
  assign wb_o.we    = we_q;
  assign wb_o.waddr = waddr_q;
  assign wb_o.wdata = lsu_rdata_i;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it.
# Exits with a failing status unless the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_name=sim_ex_stage

verilator --binary --assert -f filelist.f --top-module tb_ex_stage \
  -Mdir "$build_dir" -o "$sim_name"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$("./$build_dir/$sim_name")
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "TEST OK"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb/tb_ex_stage.sv ====
// Random testbench for the execute stage. A cycle model predicts every output and
// concurrent assertions compare it with the DUT on each rising edge after reset.

`timescale 1ns/1ps

module tb_ex_stage import ex_pkg::*; ();

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 2;
  localparam int SEED          = 12168;
  localparam int ALU_N         = 200;
  localparam int BRANCH_N      = 100;
  localparam int MULT_N        = 120;
  localparam int MULT_WAIT_MAX = 32;
  localparam int FWD_N         = 150;
  localparam int LOAD_N        = 150;
  localparam int IDLE_N        = 10;
  localparam int TESTS         = 6;
  // Worst case length of all tests with each multiplier request waiting its full limit
  localparam int TOTAL_CYCLES  = 2 * RESET_CYCLES + ALU_N + BRANCH_N
                               + MULT_N * (MULT_WAIT_MAX + 2) + FWD_N + LOAD_N + IDLE_N + 8;

  logic clk = 1'b0;
  logic rst_n;

  // DUT inputs
  alu_req_t              alu_req;
  mult_req_t             mult_req;
  logic                  alu_en, mult_en, csr_access, lsu_en, branch_in_ex;
  logic [XLEN-1:0]       csr_rdata, lsu_rdata;
  logic                  regfile_alu_we, regfile_we, lsu_ready_ex, lsu_err, wb_ready;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr, regfile_waddr;

  // DUT outputs
  rf_wr_t fw_act, wb_act;
  logic   branch_act, multicycle_act, ex_ready_act, ex_valid_act;

  // Reference model state and predictions
  logic                  mdl_busy, mdl_we;
  logic [XLEN-1:0]       mdl_high, mult_res;
  logic [REG_ADDR_W-1:0] mdl_waddr;
  logic                  start_high, mdl_mult_ready, exp_ready, exp_valid, exp_branch;
  rf_wr_t                exp_fw, exp_wb;

  string test_name = "reset";
  int    errors = 0;
  int    cycle_cnt = 0;
  int    start_cycle, start_errors;

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle_cnt++;

  ex_stage i_dut (
    .clk                (clk),
    .rst_n              (rst_n),
    .alu_req_i          (alu_req),
    .alu_en_i           (alu_en),
    .mult_req_i         (mult_req),
    .mult_en_i          (mult_en),
    .csr_access_i       (csr_access),
    .csr_rdata_i        (csr_rdata),
    .regfile_alu_we_i   (regfile_alu_we),
    .regfile_alu_waddr_i(regfile_alu_waddr),
    .regfile_we_i       (regfile_we),
    .regfile_waddr_i    (regfile_waddr),
    .branch_in_ex_i     (branch_in_ex),
    .lsu_en_i           (lsu_en),
    .lsu_rdata_i        (lsu_rdata),
    .lsu_ready_ex_i     (lsu_ready_ex),
    .lsu_err_i          (lsu_err),
    .wb_ready_i         (wb_ready),
    .alu_fw_o           (fw_act),
    .wb_o               (wb_act),
    .branch_decision_o  (branch_act),
    .mult_multicycle_o  (multicycle_act),
    .ex_ready_o         (ex_ready_act),
    .ex_valid_o         (ex_valid_act)
  );

  ////////////////////////////////////////////////////////////
  // Reference functions from the RISC-V rules
  ////////////////////////////////////////////////////////////

  function automatic logic cmp_ref(input alu_op_e op, input logic [XLEN-1:0] a, b);
    case (op)
      EQ:      return a == b;
      NE:      return a != b;
      LT:      return $signed(a) < $signed(b);
      GE:      return $signed(a) >= $signed(b);
      LTU:     return a < b;
      GEU:     return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] alu_ref(input alu_op_e op, input logic [XLEN-1:0] a, b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << sh;
      SRL:     return a >> sh;
      SRA:     return $signed(a) >>> sh;
      SLT:     return {31'b0, $signed(a) < $signed(b)};
      SLTU:    return {31'b0, a < b};
      default: return {31'b0, cmp_ref(op, a, b)};
    endcase
  endfunction

  // Upper word of the 64-bit product with operands extended as the operator demands
  function automatic logic [XLEN-1:0] mulh_ref(input mult_op_e op, input logic [XLEN-1:0] a, b);
    logic [63:0] ea, eb, p;
    ea = (op == MULHU) ? {32'b0, a} : {{32{a[31]}}, a};
    eb = (op == MULH) ? {{32{b[31]}}, b} : {32'b0, b};
    p  = ea * eb;
    return p[63:32];
  endfunction

  ////////////////////////////////////////////////////////////
  // Cycle model
  ////////////////////////////////////////////////////////////

  always_comb begin
    start_high     = mult_en && !mdl_busy && (mult_req.op != MUL);
    mdl_mult_ready = !start_high;
    exp_ready      = (mdl_mult_ready && lsu_ready_ex && wb_ready) || branch_in_ex;
    exp_valid      = (alu_en || mult_en || csr_access || lsu_en)
                     && mdl_mult_ready && lsu_ready_ex && wb_ready;
    exp_branch     = cmp_ref(alu_req.op, alu_req.operand_a, alu_req.operand_b);
    // Low word is the same for every operator
    mult_res       = mdl_busy ? mdl_high : mult_req.op_a * mult_req.op_b;
    exp_fw.we      = regfile_alu_we;
    exp_fw.waddr   = regfile_alu_waddr;
    if (csr_access) begin
      exp_fw.wdata = csr_rdata;
    end else if (mult_en) begin
      exp_fw.wdata = mult_res;
    end else if (alu_en) begin
      exp_fw.wdata = alu_ref(alu_req.op, alu_req.operand_a, alu_req.operand_b);
    end else begin
      exp_fw.wdata = '0;
    end
    exp_wb.we    = mdl_we;
    exp_wb.waddr = mdl_waddr;
    exp_wb.wdata = lsu_rdata;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mdl_busy  <= 1'b0;
      mdl_we    <= 1'b0;
      mdl_waddr <= '0;
    end else begin
      if (!mdl_busy) begin
        mdl_busy <= start_high;
      end else if (exp_ready) begin
        mdl_busy <= 1'b0;
      end
      if (start_high) begin
        mdl_high <= mulh_ref(mult_req.op, mult_req.op_a, mult_req.op_b);
      end
      if (exp_valid) begin
        mdl_we <= regfile_we && !lsu_err;
        if (regfile_we && !lsu_err) begin
          mdl_waddr <= regfile_waddr;
        end
      end else if (wb_ready) begin
        mdl_we <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string what, input logic [63:0] exp, act);
    $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
    errors++;
  endtask

  fw_port_check: assert property (@(posedge clk) disable iff (!rst_n) fw_act == exp_fw)
    else report_mismatch("alu_fw_o", 64'($sampled(exp_fw)), 64'($sampled(fw_act)));
  wb_port_check: assert property (@(posedge clk) disable iff (!rst_n) wb_act == exp_wb)
    else report_mismatch("wb_o", 64'($sampled(exp_wb)), 64'($sampled(wb_act)));
  branch_check: assert property (@(posedge clk) disable iff (!rst_n) branch_act == exp_branch)
    else report_mismatch("branch", 64'($sampled(exp_branch)), 64'($sampled(branch_act)));
  ready_check: assert property (@(posedge clk) disable iff (!rst_n) ex_ready_act == exp_ready)
    else report_mismatch("ex_ready", 64'($sampled(exp_ready)), 64'($sampled(ex_ready_act)));
  valid_check: assert property (@(posedge clk) disable iff (!rst_n) ex_valid_act == exp_valid)
    else report_mismatch("ex_valid", 64'($sampled(exp_valid)), 64'($sampled(ex_valid_act)));
  multi_check: assert property (@(posedge clk) disable iff (!rst_n) multicycle_act == start_high)
    else report_mismatch("multicycle", 64'($sampled(start_high)), 64'($sampled(multicycle_act)));

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic logic chance(input int unsigned pct);
    return ($urandom % 100) < pct;
  endfunction

  function automatic logic [REG_ADDR_W-1:0] rand_addr();
    logic [31:0] r;
    r = $urandom;
    return r[REG_ADDR_W-1:0];
  endfunction

  function automatic alu_op_e rand_alu_op(input logic cmp_only);
    logic [31:0] r;
    r = cmp_only ? 10 + ($urandom % 6) : $urandom;
    return alu_op_e'(r[3:0]);
  endfunction

  function automatic mult_op_e rand_mult_op();
    logic [31:0] r;
    r = $urandom;
    return mult_op_e'(r[1:0]);
  endfunction

  // Everything off with both downstream units ready
  task automatic drive_idle();
    alu_en         = 1'b0;
    mult_en        = 1'b0;
    csr_access     = 1'b0;
    lsu_en         = 1'b0;
    branch_in_ex   = 1'b0;
    regfile_alu_we = 1'b0;
    regfile_we     = 1'b0;
    lsu_err        = 1'b0;
    lsu_ready_ex   = 1'b1;
    wb_ready       = 1'b1;
  endtask

  task automatic rand_operands();
    alu_req.operand_a = $urandom;
    alu_req.operand_b = chance(20) ? alu_req.operand_a : $urandom;
    mult_req.op_a     = $urandom;
    mult_req.op_b     = $urandom;
    csr_rdata         = $urandom;
    lsu_rdata         = $urandom;
  endtask

  task automatic begin_test(input string name);
    test_name    = name;
    start_cycle  = cycle_cnt;
    start_errors = errors;
  endtask

  task automatic end_test();
    // Let the last stimulus cycle reach its checking edge
    @(negedge clk);
    drive_idle();
    $display("%s done: %0d cycles, %0d errors", test_name, cycle_cnt - start_cycle,
             errors - start_errors);
  endtask

  // Hold one multiplier request until the stage accepts it
  task automatic run_mult_request();
    int   waited;
    logic accepted;
    @(negedge clk);
    drive_idle();
    rand_operands();
    mult_en           = 1'b1;
    mult_req.op       = rand_mult_op();
    regfile_alu_we    = 1'b1;
    regfile_alu_waddr = rand_addr();
    wb_ready          = chance(70);
    #1;
    accepted = ex_ready_act;
    waited   = 0;
    while (!accepted && waited < MULT_WAIT_MAX) begin
      @(negedge clk);
      // Random spans of write-back back-pressure
      wb_ready = chance(60);
      #1;
      accepted = ex_ready_act;
      waited++;
    end
    if (!accepted) begin
      $display("%s: request not accepted within %0d cycles", test_name, MULT_WAIT_MAX);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    rst_n             = 1'b0;
    alu_req.op        = ADD;
    mult_req.op       = MUL;
    regfile_alu_waddr = '0;
    regfile_waddr     = '0;
    drive_idle();
    rand_operands();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    begin_test("alu");
    repeat (ALU_N) begin
      @(negedge clk);
      rand_operands();
      alu_en            = 1'b1;
      alu_req.op        = rand_alu_op(1'b0);
      regfile_alu_we    = chance(50);
      regfile_alu_waddr = rand_addr();
    end
    end_test();

    begin_test("branch");
    repeat (BRANCH_N) begin
      @(negedge clk);
      rand_operands();
      alu_en       = 1'b1;
      branch_in_ex = 1'b1;
      alu_req.op   = rand_alu_op(1'b1);
      wb_ready     = chance(50);
      lsu_ready_ex = chance(80);
    end
    end_test();

    begin_test("mult");
    repeat (MULT_N) run_mult_request();
    end_test();

    begin_test("forward");
    repeat (FWD_N) begin
      @(negedge clk);
      rand_operands();
      csr_access        = chance(40);
      mult_en           = chance(50);
      alu_en            = chance(50);
      mult_req.op       = MUL;
      alu_req.op        = rand_alu_op(1'b0);
      regfile_alu_we    = chance(50);
      regfile_alu_waddr = rand_addr();
    end
    end_test();

    begin_test("load");
    repeat (LOAD_N) begin
      @(negedge clk);
      rand_operands();
      lsu_en        = chance(70);
      regfile_we    = chance(70);
      regfile_waddr = rand_addr();
      lsu_err       = chance(25);
      wb_ready      = chance(75);
      lsu_ready_ex  = chance(90);
    end
    end_test();

    begin_test("reset");
    // Reset lands on a pending load write and a busy multiplier
    lsu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = rand_addr();
    @(negedge clk);
    drive_idle();
    mult_en     = 1'b1;
    mult_req.op = MULHU;
    // Write-back stall keeps the load write and the high word pending
    wb_ready    = 1'b0;
    @(negedge clk);
    drive_idle();
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // A high-word request only stalls if the multiplier came out of reset idle
    mult_en     = 1'b1;
    mult_req.op = MULHU;
    @(negedge clk);
    drive_idle();
    lsu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = rand_addr();
    repeat (IDLE_N) begin
      @(negedge clk);
      drive_idle();
    end
    end_test();

    $display("%0d tests run, %0d failures", TESTS, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((TOTAL_CYCLES + 100) * CLK_PERIOD);
    $display("watchdog: run did not finish in %0d cycles", TOTAL_CYCLES + 100);
    $display("TEST FAILED");
    $finish;
  end

endmodule
